// ==== common/c2h_cfg_pkg.sv ====
`default_nettype none

package c2h_cfg_pkg;

   typedef logic [15:0] cfg_addr_t;
   typedef logic [31:0] cfg_word_t;
   typedef logic [7:0]  cfg_offset_t;

   //////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////

   // Bank i spans BANK_BASE + i*BANK_SPAN up to the next bank
   localparam cfg_addr_t   BANK_BASE  = 16'h0100;
   localparam cfg_addr_t   BANK_SPAN  = 16'h0100;

   localparam cfg_offset_t CTL_OFFSET = 8'h00;
   localparam cfg_offset_t ERR_OFFSET = 8'h04;

   // Read values for holes in the map
   localparam cfg_word_t   BANK_POISON_BASE = 32'hbaad_3100;
   localparam cfg_word_t   RANGE_POISON     = 32'hbaad_3600;

   // Descriptor, data mover, write-back
   localparam int          WB_BANK_IDX = 2;

   //////////////////////////////////////////////////
   // Write-back control word
   //////////////////////////////////////////////////

   // Fields listed MSB first
   typedef struct packed {
      logic [17:0] rsvd;
      logic [5:0]  wc_cnt_minus1;
      logic [3:0]  wc_en;
      logic        md_ptr_en;
      logic        desc_cdt_en;
      logic        pkt_cnt_en;
      logic        desc_cnt_en;
   } wb_ctl_fields_t;

   typedef union packed {
      cfg_word_t      raw;
      wb_ctl_fields_t f;
   } wb_ctl_u;

endpackage

`default_nettype wire

// ==== common/cfg_bank_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface cfg_bank_if
   import c2h_cfg_pkg::*;
();

   logic        sel;
   logic        wr_stb;
   cfg_offset_t offset;
   cfg_word_t   wdata;
   cfg_word_t   rdata;

   modport decoder (
      output sel, wr_stb, offset, wdata
   );

   modport bank (
      input  sel, wr_stb, offset, wdata,
      output rdata
   );

   modport merge (
      input sel, rdata
   );

endinterface

`default_nettype wire

// ==== err_bank/cfg_err_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module cfg_err_bank
   import c2h_cfg_pkg::*;
#(
   parameter int ERR_BITS = 3,
   parameter int BANK_IDX = 0
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [ERR_BITS-1:0] err_set,
   cfg_bank_if.bank            bus,
   output cfg_word_t           ctl_word,
   output logic                bank_error
);

   // Unmapped offsets read back a per-bank marker
   localparam cfg_word_t POISON =
      BANK_POISON_BASE + cfg_word_t'(BANK_IDX) * cfg_word_t'(BANK_SPAN);

   cfg_word_t           ctl_q;
   logic [ERR_BITS-1:0] sticky_q;
   logic                ctl_wr;
   logic [ERR_BITS-1:0] err_clr;

   //////////////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////////////

   assign ctl_wr  = bus.wr_stb && (bus.offset == CTL_OFFSET);
   assign err_clr = (bus.wr_stb && (bus.offset == ERR_OFFSET)) ?
                    bus.wdata[ERR_BITS-1:0] : '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctl_q <= '0;
      end else if (ctl_wr) begin
         ctl_q <= bus.wdata;
      end
   end

   // RW1C, a new event beats a clear in the same cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sticky_q <= '0;
      end else begin
         sticky_q <= (sticky_q & ~err_clr) | err_set;
      end
   end

   //////////////////////////////////////////////////
   // Read data and summary flag
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.rdata <= '0;
      end else begin
         case (bus.offset)
            CTL_OFFSET: bus.rdata <= ctl_q;
            ERR_OFFSET: bus.rdata <= cfg_word_t'(sticky_q);
            default:    bus.rdata <= POISON;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bank_error <= 1'b0;
      end else begin
         bank_error <= |sticky_q;
      end
   end

   assign ctl_word = ctl_q;

   // Decoder must only strobe the bank it selected
   a_stb_needs_sel : assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.wr_stb |-> bus.sel
   );

endmodule

`default_nettype wire

// ==== logic/c2h_cfg_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module c2h_cfg_top
   import c2h_cfg_pkg::*;
#(
   parameter int NUM_BANKS = 3,
   parameter int ERR_BITS  = 3
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          cfg_wr_req,
   input  logic                          cfg_rd_req,
   input  cfg_addr_t                     cfg_addr,
   input  cfg_word_t                     cfg_wdata,
   input  logic [NUM_BANKS*ERR_BITS-1:0] err_set,
   output logic                          cfg_ack,
   output cfg_word_t                     cfg_rdata,
   output logic [NUM_BANKS-1:0]          bank_error,
   output logic                          wb_desc_cnt_en,
   output logic                          wb_pkt_cnt_en,
   output logic                          wb_desc_cdt_en,
   output logic                          wb_md_ptr_en,
   output logic [3:0]                    wc_en,
   output logic [5:0]                    wc_cnt_minus1
);

   logic      req_active;
   cfg_word_t ctl_word [NUM_BANKS];
   wb_ctl_u   wb_ctl;

   cfg_bank_if bank_if [NUM_BANKS] ();

   cfg_range_decode #(
      .NUM_BANKS (NUM_BANKS)
   ) u_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg_wr_req (cfg_wr_req),
      .cfg_rd_req (cfg_rd_req),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .req_active (req_active),
      .banks      (bank_if)
   );

   // Bank 0 descriptor, 1 data mover, 2 write-back
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      cfg_err_bank #(
         .ERR_BITS (ERR_BITS),
         .BANK_IDX (i)
      ) u_bank (
         .clk        (clk),
         .rst_n      (rst_n),
         .err_set    (err_set[i*ERR_BITS +: ERR_BITS]),
         .bus        (bank_if[i]),
         .ctl_word   (ctl_word[i]),
         .bank_error (bank_error[i])
      );
   end

   cfg_resp_merge #(
      .NUM_BANKS (NUM_BANKS)
   ) u_merge (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_active (req_active),
      .banks      (bank_if),
      .cfg_ack    (cfg_ack),
      .cfg_rdata  (cfg_rdata)
   );

   // Write-back field breakout
   assign wb_ctl.raw     = ctl_word[WB_BANK_IDX];
   assign wb_desc_cnt_en = wb_ctl.f.desc_cnt_en;
   assign wb_pkt_cnt_en  = wb_ctl.f.pkt_cnt_en;
   assign wb_desc_cdt_en = wb_ctl.f.desc_cdt_en;
   assign wb_md_ptr_en   = wb_ctl.f.md_ptr_en;
   assign wc_en          = wb_ctl.f.wc_en;
   assign wc_cnt_minus1  = wb_ctl.f.wc_cnt_minus1;

endmodule

`default_nettype wire

// ==== logic/cfg_range_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module cfg_range_decode
   import c2h_cfg_pkg::*;
#(
   parameter int NUM_BANKS = 3
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       cfg_wr_req,
   input  logic       cfg_rd_req,
   input  cfg_addr_t  cfg_addr,
   input  cfg_word_t  cfg_wdata,
   output logic       req_active,
   cfg_bank_if.decoder banks [NUM_BANKS]
);

   logic                 wr_q;
   logic                 rd_q;
   logic                 wr_rise;
   logic [NUM_BANKS-1:0] hit;

   //////////////////////////////////////////////////
   // Request edge detect
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end else begin
         wr_q <= cfg_wr_req;
         rd_q <= cfg_rd_req;
      end
   end

   assign req_active = wr_q | rd_q;

   // One cycle, on the first cycle of a write
   assign wr_rise = cfg_wr_req & ~wr_q;

   //////////////////////////////////////////////////
   // Bank range decode
   //////////////////////////////////////////////////

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      localparam cfg_addr_t LO = cfg_addr_t'(BANK_BASE + i * BANK_SPAN);
      localparam cfg_addr_t HI = cfg_addr_t'(BANK_BASE + (i + 1) * BANK_SPAN);

      assign hit[i]          = (cfg_addr >= LO) && (cfg_addr < HI);
      assign banks[i].sel    = hit[i];
      assign banks[i].wr_stb = wr_rise & hit[i];
      // Banks are aligned to their span, so the low byte is the offset
      assign banks[i].offset = cfg_addr[$bits(cfg_offset_t)-1:0];
      assign banks[i].wdata  = cfg_wdata;
   end

   // Host protocol allows one request type at a time
   a_one_req_type : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(cfg_wr_req && cfg_rd_req)
   );

endmodule

`default_nettype wire

// ==== logic/cfg_resp_merge.sv ====
`default_nettype none
`timescale 1ns/1ps

module cfg_resp_merge
   import c2h_cfg_pkg::*;
#(
   parameter int NUM_BANKS = 3
) (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      req_active,
   cfg_bank_if.merge banks [NUM_BANKS],
   output logic      cfg_ack,
   output cfg_word_t cfg_rdata
);

   logic [NUM_BANKS-1:0] sel_vec;
   cfg_word_t            bank_rdata [NUM_BANKS];
   cfg_word_t            mux_rdata;

   // Flatten the interface array for the mux
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_gather
      assign sel_vec[i]    = banks[i].sel;
      assign bank_rdata[i] = banks[i].rdata;
   end

   always_comb begin
      mux_rdata = RANGE_POISON;
      for (int i = 0; i < NUM_BANKS; i++) begin
         if (sel_vec[i]) begin
            mux_rdata = bank_rdata[i];
         end
      end
   end

   //////////////////////////////////////////////////
   // Response registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg_ack   <= 1'b0;
         cfg_rdata <= '0;
      end else begin
         cfg_ack <= req_active;
         // Capture on the ack edge, then hold while ack is up
         if (req_active && !cfg_ack) begin
            cfg_rdata <= mux_rdata;
         end
      end
   end

   // Bank ranges never overlap
   a_sel_onehot : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(sel_vec)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the C2H config register testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sim.f --top-module tb_c2h_cfg -Mdir "$OBJ" -o tb_c2h_cfg
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/tb_c2h_cfg" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

echo "Simulation finished cleanly"
exit 0

// ==== sim.f ====
common/c2h_cfg_pkg.sv
common/cfg_bank_if.sv
logic/cfg_range_decode.sv
err_bank/cfg_err_bank.sv
logic/cfg_resp_merge.sv
logic/c2h_cfg_top.sv
sim/tb_c2h_cfg.sv

// ==== sim/tb_c2h_cfg.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_c2h_cfg
   import c2h_cfg_pkg::*;
();

   localparam int NUM_BANKS = 3;
   localparam int ERR_BITS  = 3;
   localparam int TIMEOUT   = 50;

   logic                          clk;
   logic                          rst_n;
   logic                          cfg_wr_req;
   logic                          cfg_rd_req;
   cfg_addr_t                     cfg_addr;
   cfg_word_t                     cfg_wdata;
   logic [NUM_BANKS*ERR_BITS-1:0] err_set;
   logic                          cfg_ack;
   cfg_word_t                     cfg_rdata;
   logic [NUM_BANKS-1:0]          bank_error;
   logic                          wb_desc_cnt_en;
   logic                          wb_pkt_cnt_en;
   logic                          wb_desc_cdt_en;
   logic                          wb_md_ptr_en;
   logic [3:0]                    wc_en;
   logic [5:0]                    wc_cnt_minus1;

   integer                        seed;
   logic                          req_q;
   logic                          ack_q;
   logic [1:0]                    rise_pipe;
   cfg_word_t                     rdata_q;

   c2h_cfg_top #(
      .NUM_BANKS (NUM_BANKS),
      .ERR_BITS  (ERR_BITS)
   ) dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .cfg_wr_req     (cfg_wr_req),
      .cfg_rd_req     (cfg_rd_req),
      .cfg_addr       (cfg_addr),
      .cfg_wdata      (cfg_wdata),
      .err_set        (err_set),
      .cfg_ack        (cfg_ack),
      .cfg_rdata      (cfg_rdata),
      .bank_error     (bank_error),
      .wb_desc_cnt_en (wb_desc_cnt_en),
      .wb_pkt_cnt_en  (wb_pkt_cnt_en),
      .wb_desc_cdt_en (wb_desc_cdt_en),
      .wb_md_ptr_en   (wb_md_ptr_en),
      .wc_en          (wc_en),
      .wc_cnt_minus1  (wc_cnt_minus1)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Protocol monitors
   //////////////////////////////////////////////////

   // Request edge history, two stages deep to line up with the ack
   always @(posedge clk) begin
      if (!rst_n) begin
         req_q     <= 1'b0;
         ack_q     <= 1'b0;
         rise_pipe <= 2'b00;
         rdata_q   <= '0;
      end else begin
         req_q     <= cfg_wr_req | cfg_rd_req;
         ack_q     <= cfg_ack;
         rise_pipe <= {rise_pipe[0], (cfg_wr_req | cfg_rd_req) & ~req_q};
         rdata_q   <= cfg_rdata;
      end
   end

   a_ack_latency : assert property (
      @(posedge clk) disable iff (!rst_n)
      (cfg_ack && !ack_q) == rise_pipe[1]
   ) else report_mismatch("ack_latency", cfg_word_t'($sampled(rise_pipe[1])),
                          cfg_word_t'($sampled(cfg_ack && !ack_q)));

   // Read data holds while ack stays up
   a_rdata_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      (cfg_ack && ack_q) |-> (cfg_rdata == rdata_q)
   ) else report_mismatch("rdata_hold", $sampled(rdata_q), $sampled(cfg_rdata));

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic report_mismatch(input string name, input cfg_word_t exp_word,
                                  input cfg_word_t act_word);
      $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp_word, act_word);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic report_problem(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input cfg_word_t exp_word,
                             input cfg_word_t act_word);
      assert (act_word === exp_word) else report_mismatch(name, exp_word, act_word);
   endtask

   // Polls on the falling edge, where DUT outputs are settled
   task automatic wait_ack(input logic level);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen) begin
         @(negedge clk);
         if (cfg_ack === level) begin
            seen = 1'b1;
         end else if (cycles == TIMEOUT) begin
            report_problem($sformatf("Timed out waiting for cfg_ack to go %0d", level));
         end
         cycles++;
      end
   endtask

   task automatic bus_access(input logic write, input cfg_addr_t addr,
                             input cfg_word_t wdata, output cfg_word_t rdata);
      @(posedge clk);
      cfg_addr   <= addr;
      cfg_wdata  <= wdata;
      cfg_wr_req <= write;
      cfg_rd_req <= !write;
      wait_ack(1'b1);
      rdata = cfg_rdata;
      @(posedge clk);
      cfg_wr_req <= 1'b0;
      cfg_rd_req <= 1'b0;
      wait_ack(1'b0);
   endtask

   // Prior returns the register value seen during the write
   task automatic write_reg(input cfg_addr_t addr, input cfg_word_t data,
                            output cfg_word_t prior);
      bus_access(1'b1, addr, data, prior);
   endtask

   task automatic read_reg(input cfg_addr_t addr, output cfg_word_t data);
      bus_access(1'b0, addr, '0, data);
   endtask

   function automatic cfg_addr_t bank_addr(input int bank, input cfg_offset_t offset);
      return cfg_addr_t'(BANK_BASE + bank * BANK_SPAN + offset);
   endfunction

   // Field outputs packed back in control word bit order
   function automatic cfg_word_t wb_fields();
      return cfg_word_t'({wc_cnt_minus1, wc_en, wb_md_ptr_en, wb_desc_cdt_en,
                          wb_pkt_cnt_en, wb_desc_cnt_en});
   endfunction

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial begin
      cfg_word_t data;
      cfg_word_t got;
      cfg_word_t old;
      cfg_word_t exp_word;
      cfg_word_t ctl_model [NUM_BANKS];
      cfg_addr_t outside [4];
      int        bit_idx;
      seed       = 32'h1ed6;
      outside    = '{16'h0000, 16'h00fc, 16'h0400, 16'hfffc};
      foreach (ctl_model[i]) ctl_model[i] = '0;
      rst_n      <= 1'b0;
      cfg_wr_req <= 1'b0;
      cfg_rd_req <= 1'b0;
      cfg_addr   <= '0;
      cfg_wdata  <= '0;
      err_set    <= '0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);

      check_word("reset_ack", 32'h0, cfg_word_t'(cfg_ack));
      check_word("reset_bank_error", 32'h0, cfg_word_t'(bank_error));
      check_word("reset_wb_fields", 32'h0, wb_fields());
      check_word("reset_rdata", 32'h0, cfg_rdata);

      // Control word write and read back in every bank
      for (int b = 0; b < NUM_BANKS; b++) begin
         data = cfg_word_t'($random(seed));
         write_reg(bank_addr(b, CTL_OFFSET), data, old);
         check_word($sformatf("ctl_prior_bank%0d", b), ctl_model[b], old);
         ctl_model[b] = data;
         read_reg(bank_addr(b, CTL_OFFSET), got);
         check_word($sformatf("ctl_readback_bank%0d", b), data, got);
      end

      // Sticky error bits set by a pulse and cleared by writing 1
      for (int b = 0; b < NUM_BANKS; b++) begin
         bit_idx  = int'($unsigned($random(seed)) % ERR_BITS);
         exp_word = cfg_word_t'(1) << bit_idx;
         @(posedge clk);
         err_set[b*ERR_BITS + bit_idx] <= 1'b1;
         @(posedge clk);
         err_set <= '0;
         read_reg(bank_addr(b, ERR_OFFSET), got);
         check_word($sformatf("err_set_bank%0d", b), exp_word, got);
         check_word("bank_error_set", cfg_word_t'(1) << b, cfg_word_t'(bank_error));
         for (int o = 0; o < NUM_BANKS; o++) begin
            if (o != b) begin
               read_reg(bank_addr(o, ERR_OFFSET), got);
               check_word($sformatf("err_other_bank%0d", o), 32'h0, got);
            end
         end
         write_reg(bank_addr(b, ERR_OFFSET), ~exp_word, old);
         read_reg(bank_addr(b, ERR_OFFSET), got);
         check_word($sformatf("err_w0_bank%0d", b), exp_word, got);
         write_reg(bank_addr(b, ERR_OFFSET), exp_word, old);
         read_reg(bank_addr(b, ERR_OFFSET), got);
         check_word($sformatf("err_w1c_bank%0d", b), 32'h0, got);
         check_word("bank_error_clear", 32'h0, cfg_word_t'(bank_error));
      end

      // Write-back control fields
      for (int n = 0; n < 4; n++) begin
         data = cfg_word_t'($random(seed));
         write_reg(bank_addr(WB_BANK_IDX, CTL_OFFSET), data, old);
         check_word("wb_prior", ctl_model[WB_BANK_IDX], old);
         ctl_model[WB_BANK_IDX] = data;
         check_word("wb_fields", {18'b0, data[13:0]}, wb_fields());
      end

      // Holes in the map
      for (int b = 0; b < NUM_BANKS; b++) begin
         exp_word = BANK_POISON_BASE + cfg_word_t'(b) * 32'h100;
         read_reg(bank_addr(b, 8'h08), got);
         check_word($sformatf("bank_poison_08_bank%0d", b), exp_word, got);
         read_reg(bank_addr(b, 8'hfc), got);
         check_word($sformatf("bank_poison_fc_bank%0d", b), exp_word, got);
      end
      foreach (outside[i]) begin
         read_reg(outside[i], got);
         check_word($sformatf("range_poison_%04h", outside[i]), RANGE_POISON, got);
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire
